// File: all.f
+incdir+src
src/yuv_pkg.sv
src/frame_addr_gen.sv
src/rdata_channel.sv
src/plane_fifo.sv
src/group_emitter.sv
src/yuv_frame_reader.sv
test/axi_mem_model.sv
test/tb_yuv_frame_reader.sv

// File: src/frame_addr_gen.sv
/*
 * Frame address generator
 * Issues one three-beat AXI read burst per group and waits for the
 * burst to return before moving to the next group address
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module frame_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_pulse,
    input  logic [`YUV_ADDR_W-1:0] base_addr,
    input  logic [`YUV_CNT_W-1:0]  group_count,
    output yuv_pkg::axi_ar_t       ar,
    input  logic                   arready,
    input  logic                   burst_done,
    output logic                   busy,
    output logic                   done
);
    import yuv_pkg::*;

    // Bytes spanned by one group of beats
    localparam logic [`YUV_ADDR_W-1:0] GROUP_BYTES =
        `YUV_ADDR_W'(`YUV_BEATS * (`YUV_DATA_W / 8));
    localparam logic [7:0] BURST_LEN = 8'(`YUV_BEATS - 1);

    axi_ar_t               ar_q;
    logic [`YUV_CNT_W-1:0] remaining;
    logic                  busy_q;
    logic                  done_q;

    // ----------------------------------------
    // Request sequencing
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_q      <= '0;
            remaining <= '0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (!busy_q) begin
                // Start only honoured while idle
                if (start_pulse) begin
                    ar_q.addr  <= base_addr;
                    ar_q.id    <= '0;
                    ar_q.len   <= BURST_LEN;
                    ar_q.valid <= 1'b1;
                    remaining  <= group_count;
                    busy_q     <= 1'b1;
                end
            end else if (ar_q.valid) begin
                if (arready) begin
                    ar_q.valid <= 1'b0;
                end
            end else if (burst_done) begin
                if (remaining == `YUV_CNT_W'(1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    ar_q.addr  <= ar_q.addr + GROUP_BYTES;
                    ar_q.valid <= 1'b1;
                    remaining  <= remaining - 1'b1;
                end
            end
        end
    end

    assign ar   = ar_q;
    assign busy = busy_q;
    assign done = done_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // A pending request keeps its address until the slave takes it
    property p_ar_hold;
        @(posedge clk) disable iff (!rst_n)
        ar_q.valid && !arready |=> ar_q.valid && $stable(ar_q.addr);
    endproperty
    a_ar_hold: assert property (p_ar_hold);

endmodule

// File: src/group_emitter.sv
/*
 * Group emitter
 * Pops one word from each plane FIFO together and presents
 * them as a single registered group word with a strobe
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module group_emitter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   y0_empty,
    input  logic                   y1_empty,
    input  logic                   uv_empty,
    input  logic [`YUV_DATA_W-1:0] y0_word,
    input  logic [`YUV_DATA_W-1:0] y1_word,
    input  logic [`YUV_DATA_W-1:0] uv_word,
    input  logic                   out_stall,
    output logic                   pop,
    output yuv_pkg::yuv_group_t    out_group,
    output logic                   out_valid
);

    // All three planes must be present; stall blocks the pop itself
    assign pop = !y0_empty && !y1_empty && !uv_empty && !out_stall;

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (pop) begin
            out_group.y0 <= y0_word;
            out_group.y1 <= y1_word;
            out_group.uv <= uv_word;
        end
    end

    // Strobe follows the pop by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
        end
    end

endmodule

// File: src/plane_fifo.sv
/*
 * Plane FIFO
 * Register-array FIFO with first-word-fall-through output,
 * one per image plane
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module plane_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr,
    input  logic [`YUV_DATA_W-1:0] din,
    input  logic                   rd,
    output logic [`YUV_DATA_W-1:0] dout,
    output logic                   full,
    output logic                   empty
);

    localparam int DEPTH = `YUV_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`YUV_DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       level;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head entry is always on the output
    assign dout = mem[rd_ptr];

    // ----------------------------------------
    // Pointers and fill level
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr && !rd) begin
                level <= level + 1'b1;
            end else if (rd && !wr) begin
                level <= level - 1'b1;
            end
        end
    end

    assign full  = (level == CNT_W'(DEPTH));
    assign empty = (level == '0);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) wr |-> !full
    );
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) rd |-> !empty
    );

endmodule

// File: src/rdata_channel.sv
/*
 * Read data channel
 * Sorts the beats of each burst onto the Y0, Y1 and UV plane lines
 * and writes all three plane FIFOs together on the last beat
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module rdata_channel (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_pulse,
    input  yuv_pkg::axi_r_t      r,
    output logic                 rready,
    input  logic                 y0_full,
    output logic                 rd_error,
    output logic                 burst_done,
    output logic                 plane_wr,
    output yuv_pkg::yuv_group_t  plane_data
);

    localparam logic [1:0] LAST_BEAT = 2'(`YUV_BEATS - 1);

    logic                   beat_acc;
    logic [1:0]             count;
    logic [`YUV_DATA_W-1:0] y0_q;
    logic [`YUV_DATA_W-1:0] y1_q;

    // Only hold off at a burst boundary; mid-burst the FIFOs are
    // guaranteed a slot since they fill in lockstep
    assign rready     = !y0_full || (count != 2'd0);
    assign beat_acc   = r.valid && rready;
    assign burst_done = beat_acc && r.last;
    assign plane_wr   = burst_done;

    // ----------------------------------------
    // Beat counter
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= 2'd0;
        end else if (start_pulse) begin
            count <= 2'd0;
        end else if (beat_acc) begin
            if (count == LAST_BEAT) begin
                count <= 2'd0;
            end else begin
                count <= count + 2'd1;
            end
        end
    end

    // ----------------------------------------
    // Plane routing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (beat_acc) begin
            case (count)
                2'd0:    y0_q <= r.data;
                2'd1:    y1_q <= r.data;
                default: ;
            endcase
        end
    end

    // UV is the live last beat, no register
    assign plane_data = '{y0: y0_q, y1: y1_q, uv: r.data};

    // Status of the most recently accepted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_error <= 1'b0;
        end else if (beat_acc) begin
            rd_error <= (r.resp != 2'b00);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_count_range: assert property (
        @(posedge clk) disable iff (!rst_n) count <= LAST_BEAT
    );

    // Slave burst length has to match the group shape
    a_last_align: assert property (
        @(posedge clk) disable iff (!rst_n) beat_acc && r.last |-> count == LAST_BEAT
    );

endmodule

// File: src/yuv_frame_reader.sv
/*
 * YUV frame reader top
 * AXI read master that fetches planar Y0/Y1/UV groups and
 * regroups them through three plane FIFOs
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module yuv_frame_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_pulse,
    input  logic [`YUV_ADDR_W-1:0] base_addr,
    input  logic [`YUV_CNT_W-1:0]  group_count,
    output yuv_pkg::axi_ar_t       ar,
    input  logic                   arready,
    input  yuv_pkg::axi_r_t        r,
    output logic                   rready,
    output logic                   rd_error,
    output logic                   busy,
    output logic                   done,
    output yuv_pkg::yuv_group_t    out_group,
    output logic                   out_valid,
    input  logic                   out_stall
);
    import yuv_pkg::*;

    logic                   start_acc;
    logic                   burst_done;
    logic                   plane_wr;
    yuv_group_t             plane_data;
    logic                   pop;
    logic                   y0_full;
    logic                   y0_empty;
    logic                   y1_empty;
    logic                   uv_empty;
    logic [`YUV_DATA_W-1:0] y0_word;
    logic [`YUV_DATA_W-1:0] y1_word;
    logic [`YUV_DATA_W-1:0] uv_word;

    // A start during a run must not disturb the beat counter
    assign start_acc = start_pulse && !busy;

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    frame_addr_gen u_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .base_addr   (base_addr),
        .group_count (group_count),
        .ar          (ar),
        .arready     (arready),
        .burst_done  (burst_done),
        .busy        (busy),
        .done        (done)
    );

    rdata_channel u_rdata (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_acc),
        .r           (r),
        .rready      (rready),
        .y0_full     (y0_full),
        .rd_error    (rd_error),
        .burst_done  (burst_done),
        .plane_wr    (plane_wr),
        .plane_data  (plane_data)
    );

    // ----------------------------------------
    // Plane FIFOs
    // ----------------------------------------
    // Shared write and pop keep the planes level, so Y0 full stands for all
    plane_fifo u_y0_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (plane_wr),
        .din   (plane_data.y0),
        .rd    (pop),
        .dout  (y0_word),
        .full  (y0_full),
        .empty (y0_empty)
    );

    plane_fifo u_y1_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (plane_wr),
        .din   (plane_data.y1),
        .rd    (pop),
        .dout  (y1_word),
        .full  (),
        .empty (y1_empty)
    );

    plane_fifo u_uv_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (plane_wr),
        .din   (plane_data.uv),
        .rd    (pop),
        .dout  (uv_word),
        .full  (),
        .empty (uv_empty)
    );

    // ----------------------------------------
    // Output side
    // ----------------------------------------
    group_emitter u_emitter (
        .clk       (clk),
        .rst_n     (rst_n),
        .y0_empty  (y0_empty),
        .y1_empty  (y1_empty),
        .uv_empty  (uv_empty),
        .y0_word   (y0_word),
        .y1_word   (y1_word),
        .uv_word   (uv_word),
        .out_stall (out_stall),
        .pop       (pop),
        .out_group (out_group),
        .out_valid (out_valid)
    );

endmodule

// File: src/yuv_params.svh
/*
 * YUV frame reader parameters
 * Bus widths, burst shape and plane FIFO sizing
 */
`ifndef YUV_PARAMS_SVH
`define YUV_PARAMS_SVH

// ----------------------------------------
// AXI read bus
// ----------------------------------------
`define YUV_DATA_W      64
`define YUV_ADDR_W      32
`define YUV_ID_W        2

// ----------------------------------------
// Frame grouping
// ----------------------------------------
// One group is Y0, Y1 and UV, one beat each
`define YUV_BEATS       3
`define YUV_FIFO_DEPTH  8
`define YUV_CNT_W       16

`endif

// File: src/yuv_pkg.sv
/*
 * YUV frame reader types
 * AXI read address and read data channel bundles,
 * plus the three-plane group word
 */
`include "yuv_params.svh"

package yuv_pkg;

    // ----------------------------------------
    // AXI read address channel
    // ----------------------------------------
    typedef struct packed {
        logic [`YUV_ADDR_W-1:0] addr;
        logic [`YUV_ID_W-1:0]   id;
        // Beats minus one, as on the bus
        logic [7:0]             len;
        logic                   valid;
    } axi_ar_t;

    // ----------------------------------------
    // AXI read data channel
    // ----------------------------------------
    typedef struct packed {
        logic [`YUV_DATA_W-1:0] data;
        logic [`YUV_ID_W-1:0]   id;
        logic [1:0]             resp;
        logic                   last;
        logic                   valid;
    } axi_r_t;

    // ----------------------------------------
    // One sorted group, one word per plane
    // ----------------------------------------
    typedef struct packed {
        logic [`YUV_DATA_W-1:0] y0;
        logic [`YUV_DATA_W-1:0] y1;
        logic [`YUV_DATA_W-1:0] uv;
    } yuv_group_t;

endpackage

// File: test/axi_mem_model.sv
/*
 * AXI read slave model
 * Answers each burst with address-tagged beats after random delays
 * and can flag one chosen beat with an error response
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module axi_mem_model (
    input  logic             clk,
    input  logic             rst_n,
    input  yuv_pkg::axi_ar_t ar,
    output logic             arready,
    output yuv_pkg::axi_r_t  r,
    input  logic             rready,
    input  logic [1:0]       err_beat
);
    import yuv_pkg::*;

    // Chance in percent that a beat slot stays empty
    localparam int GAP_PCT = 25;

    logic [`YUV_ADDR_W-1:0] burst_addr;
    logic [1:0]             next_beat;
    logic                   active;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready    <= 1'b0;
            r          <= '0;
            burst_addr <= '0;
            next_beat  <= '0;
            active     <= 1'b0;
        end else if (!active) begin
            if (ar.valid && arready) begin
                burst_addr <= ar.addr;
                next_beat  <= '0;
                active     <= 1'b1;
                arready    <= 1'b0;
            end else begin
                arready <= ($urandom % 4) != 0;
            end
        end else if (r.valid && rready && r.last) begin
            // Burst complete, back to waiting for an address
            r.valid <= 1'b0;
            active  <= 1'b0;
        end else if (!r.valid || rready) begin
            if (($urandom % 100) < GAP_PCT) begin
                r.valid <= 1'b0;
            end else begin
                // Upper half is the beat address, lower half the beat index
                r.data  <= {burst_addr + (`YUV_ADDR_W'(next_beat) << 3), 32'(next_beat)};
                r.id    <= '0;
                r.resp  <= (next_beat == err_beat) ? 2'b10 : 2'b00;
                r.last  <= (next_beat == 2'(`YUV_BEATS - 1));
                r.valid <= 1'b1;
                next_beat <= next_beat + 2'd1;
            end
        end
    end

endmodule

// File: test/tb_yuv_frame_reader.sv
/*
 * YUV frame reader testbench
 * Runs a table of frame reads against an AXI slave model and checks
 * group contents, done pulses, error status and stall recovery
 */
`timescale 1ns/1ps
`include "yuv_params.svh"

module tb_yuv_frame_reader;
    import yuv_pkg::*;

    localparam int NROWS = 5;

    logic                   clk;
    logic                   rst_n;
    logic                   start_pulse;
    logic [`YUV_ADDR_W-1:0] base_addr;
    logic [`YUV_CNT_W-1:0]  group_count;
    axi_ar_t                ar;
    logic                   arready;
    axi_r_t                 r;
    logic                   rready;
    logic                   rd_error;
    logic                   busy;
    logic                   done;
    yuv_group_t             out_group;
    logic                   out_valid;
    logic                   out_stall;
    logic [1:0]             err_beat;

    // Stimulus table, one entry per row
    string                  row_name [NROWS];
    logic [`YUV_ADDR_W-1:0] row_base [NROWS];
    int                     row_groups [NROWS];
    int                     row_err [NROWS];
    int                     row_stall [NROWS];
    int                     row_hold [NROWS];
    bit                     row_restart [NROWS];

    int cur = 0;
    int groups_seen = 0;
    int done_seen = 0;
    int beat_idx = 0;
    int ars_seen = 0;
    int lasts_seen = 0;
    int row_cycle = 0;
    int cycles = 0;
    int cycle_limit = 0;
    bit err_pending = 1'b0;
    bit exp_err = 1'b0;
    bit final_pending = 1'b0;

    yuv_frame_reader i_yuv_frame_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_pulse (start_pulse),
        .base_addr   (base_addr),
        .group_count (group_count),
        .ar          (ar),
        .arready     (arready),
        .r           (r),
        .rready      (rready),
        .rd_error    (rd_error),
        .busy        (busy),
        .done        (done),
        .out_group   (out_group),
        .out_valid   (out_valid),
        .out_stall   (out_stall)
    );

    axi_mem_model u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (ar),
        .arready  (arready),
        .r        (r),
        .rready   (rready),
        .err_beat (err_beat)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string what, input logic [191:0] exp_val,
                                   input logic [191:0] act_val);
        $display("ERR %s expected %0h actual %0h", what, exp_val, act_val);
        $display("Errors found");
        $fatal(1, "Check failed in %s", what);
    endtask

    task automatic add_row(input int i, input string name, input logic [31:0] base,
                           input int groups, input int eb, input int stall,
                           input int hold, input bit restart);
        row_name[i]    = name;
        row_base[i]    = base;
        row_groups[i]  = groups;
        row_err[i]     = eb;
        row_stall[i]   = stall;
        row_hold[i]    = hold;
        row_restart[i] = restart;
    endtask

    // ----------------------------------------
    // One table row, start to final checks
    // ----------------------------------------
    task automatic run_row(input int i);
        @(negedge clk);
        cur         = i;
        groups_seen = 0;
        done_seen   = 0;
        beat_idx    = 0;
        ars_seen    = 0;
        lasts_seen  = 0;
        @(posedge clk);
        base_addr   <= row_base[i];
        group_count <= `YUV_CNT_W'(row_groups[i]);
        err_beat    <= 2'(row_err[i]);
        start_pulse <= 1'b1;
        @(posedge clk);
        start_pulse <= 1'b0;
        if (row_restart[i]) begin
            // Second start mid-run with a different count and base
            repeat (6) @(posedge clk);
            base_addr   <= 32'hdead_0000;
            group_count <= `YUV_CNT_W'(1);
            start_pulse <= 1'b1;
            @(posedge clk);
            start_pulse <= 1'b0;
        end
        while (done_seen == 0 || groups_seen < row_groups[i]) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (done_seen == 1)
            else report_mismatch({row_name[i], " done pulses"}, 1, done_seen);
        assert (groups_seen == row_groups[i])
            else report_mismatch({row_name[i], " group count"}, row_groups[i], groups_seen);
        assert (rd_error == (row_err[i] == 2))
            else report_mismatch({row_name[i], " final rd_error"}, row_err[i] == 2, rd_error);
        assert (!busy)
            else report_mismatch({row_name[i], " busy after done"}, 0, busy);
    endtask

    // Stall pattern, a solid hold first and then random per row
    always @(posedge clk) begin
        if (start_pulse) begin
            row_cycle <= 0;
        end else begin
            row_cycle <= row_cycle + 1;
        end
        if (row_cycle < row_hold[cur]) begin
            out_stall <= 1'b1;
        end else begin
            out_stall <= ($urandom % 100) < row_stall[cur];
        end
    end

    // ----------------------------------------
    // Output and status checks
    // ----------------------------------------
    always @(negedge clk) begin : watch_outputs
        logic [`YUV_ADDR_W-1:0] gaddr;
        yuv_group_t             exp_group;
        axi_ar_t                exp_ar;
        int                     fill;
        logic                   exp_rready;
        if (rst_n) begin
            if (err_pending) begin
                assert (rd_error == exp_err)
                    else report_mismatch({row_name[cur], " rd_error"}, exp_err, rd_error);
                err_pending = 1'b0;
            end
            // Final burst of the row went in on the last edge
            if (final_pending) begin
                assert (done && !busy)
                    else report_mismatch({row_name[cur], " done and busy"}, 2'b10,
                                         {done, busy});
                final_pending = 1'b0;
            end
            if (out_valid) begin
                gaddr        = row_base[cur] + `YUV_ADDR_W'(24 * groups_seen);
                exp_group.y0 = {gaddr, 32'd0};
                exp_group.y1 = {gaddr + 32'd8, 32'd1};
                exp_group.uv = {gaddr + 32'd16, 32'd2};
                assert (out_group == exp_group)
                    else report_mismatch({row_name[cur], " group data"}, exp_group, out_group);
                groups_seen++;
            end
            // Plane FIFO level after the last edge
            fill       = lasts_seen - groups_seen;
            exp_rready = (fill < `YUV_FIFO_DEPTH) || (beat_idx != 0);
            assert (rready == exp_rready)
                else report_mismatch({row_name[cur], " rready"}, exp_rready, rready);
            if (ar.valid && arready) begin
                exp_ar.addr  = row_base[cur] + `YUV_ADDR_W'(24 * ars_seen);
                exp_ar.id    = '0;
                exp_ar.len   = 8'd2;
                exp_ar.valid = 1'b1;
                assert (ar == exp_ar)
                    else report_mismatch({row_name[cur], " read address"}, exp_ar, ar);
                ars_seen++;
            end
            // Beat accepted on the coming edge
            if (r.valid && rready) begin
                exp_err     = (beat_idx == row_err[cur]);
                beat_idx    = (beat_idx + 1) % 3;
                err_pending = 1'b1;
                if (r.last) begin
                    lasts_seen++;
                    final_pending = (lasts_seen == row_groups[cur]);
                end
            end
            if (done) begin
                done_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    initial begin
        rst_n       = 1'b0;
        start_pulse = 1'b0;
        base_addr   = '0;
        group_count = '0;
        out_stall   = 1'b0;
        err_beat    = 2'd3;
        void'($urandom(50560));
        // Error beat 3 means no error beat
        add_row(0, "basic",        32'h1000_0000,  4, 3,  0,   0, 1'b0);
        add_row(1, "err_beat1",    32'h2000_0100,  3, 1, 20,   0, 1'b0);
        add_row(2, "err_beat2",    32'h3000_0040,  5, 2, 30,   0, 1'b0);
        add_row(3, "backpressure", 32'h4000_0000, 14, 3, 10, 120, 1'b0);
        add_row(4, "restart",      32'h5000_0800,  6, 0, 50,   0, 1'b1);
        foreach (row_groups[i]) begin
            cycle_limit += 60 * row_groups[i];
        end
        cycle_limit += 200;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!out_valid && !done && !busy && !rd_error && !ar.valid)
            else report_mismatch("reset state", 0,
                                 {out_valid, done, busy, rd_error, ar.valid});

        for (int i = 0; i < NROWS; i++) begin
            run_row(i);
        end
        $display("No errors");
        $finish;
    end

endmodule
